//--- rtl/periph_cfg.svh
`ifndef PERIPH_CFG_SVH
`define PERIPH_CFG_SVH

// region select, compared against address bits 31:16
// each region spans 64 KB
`define PERIPH_REGION_SRAM  16'h0200
`define PERIPH_REGION_CACHE 16'h0201
`define PERIPH_REGION_IRQ   16'h0202
`define PERIPH_REGION_VGA   16'h0206
`define PERIPH_REGION_KBD   16'h0207

// main sram depth in 32-bit words
`define PERIPH_SRAM_WORDS 512

// vga mode out of reset
`define PERIPH_VGA_MODE_RESET 3

// clk cycles without a ps2 clock edge before a partial frame is dropped
// the idle counter saturates here
`define PERIPH_KBD_IDLE_LIMIT 16'd65535

// pending bit driven by the keyboard valid flag
`define PERIPH_IRQ_KBD_BIT 0

`endif

//--- rtl/periph_pkg.sv
`default_nettype none

package periph_pkg;

  // cpu bus
  typedef logic [31:0] bus_addr_t;    // byte address
  typedef logic [31:0] bus_data_t;
  typedef logic [3:0]  byte_en_t;

  // word offset inside a 64 KB region, address bits 15:2
  typedef logic [13:0] reg_offset_t;

  typedef logic [8:0]  sram_addr_t;   // 512 words

  // cache and vga control fields
  typedef logic [14:0] flush_page_t;
  typedef logic [15:0] line_addr_t;   // 64k lines of 2 KB
  typedef logic [1:0]  vga_mode_t;

  // start, 8 data, parity, stop
  typedef logic [10:0] ps2_frame_t;

  typedef logic [31:0] irq_vec_t;     // one bit per source

endpackage

`default_nettype wire

//--- rtl/bus_decoder.sv
`timescale 1ns/1ps
`default_nettype none
`include "periph_cfg.svh"

module bus_decoder (
  input  wire periph_pkg::bus_addr_t  bus_address,
  input  wire logic                   bus_read,
  input  wire logic                   bus_write,
  input  wire periph_pkg::bus_data_t  sram_readdata,
  input  wire periph_pkg::bus_data_t  irq_readdata,
  input  wire logic                   sram_waitrequest,
  input  wire periph_pkg::ps2_frame_t kbd_frame,
  input  wire logic                   kbd_valid,
  output periph_pkg::reg_offset_t     offset,
  output periph_pkg::sram_addr_t      sram_addr,
  output logic                        sram_read,
  output logic                        sram_write,
  output logic                        cache_write,
  output logic                        irq_write,
  output logic                        vga_write,
  output logic                        kbd_read,
  output periph_pkg::bus_data_t       bus_readdata,
  output logic                        bus_waitrequest
);
  import periph_pkg::*;

  logic      sram_cs;
  logic      cache_cs;
  logic      irq_cs;
  logic      vga_cs;
  logic      kbd_cs;
  bus_data_t kbd_readdata;

  assign sram_cs  = (bus_address[31:16] == `PERIPH_REGION_SRAM);
  assign cache_cs = (bus_address[31:16] == `PERIPH_REGION_CACHE);
  assign irq_cs   = (bus_address[31:16] == `PERIPH_REGION_IRQ);
  assign vga_cs   = (bus_address[31:16] == `PERIPH_REGION_VGA);
  assign kbd_cs   = (bus_address[31:16] == `PERIPH_REGION_KBD);

  assign offset    = bus_address[15:2];
  assign sram_addr = bus_address[10:2]; // 2 KB, rest of the region aliases

  assign sram_read   = sram_cs && bus_read;
  assign sram_write  = sram_cs && bus_write;
  assign cache_write = cache_cs && bus_write;
  assign irq_write   = irq_cs && bus_write;
  assign vga_write   = vga_cs && bus_write;
  assign kbd_read    = kbd_cs && bus_read;

  assign kbd_readdata = {20'd0, kbd_valid, kbd_frame}; // valid sits above the frame

  // cache and vga are write only, they fall through to 0 like unmapped space
  always_comb begin
    bus_waitrequest = 1'b0;
    bus_readdata    = '0;
    if (sram_cs) begin
      bus_waitrequest = sram_waitrequest;
      bus_readdata    = sram_readdata;
    end else if (irq_cs) begin
      bus_readdata = irq_readdata;
    end else if (kbd_cs) begin
      bus_readdata = kbd_readdata;
    end
  end

  // region compare plus master strobes, only one slave may see an access
  always_comb begin
    if (!$isunknown({bus_address, bus_read, bus_write})) begin
      assert ($onehot0({sram_read, sram_write, cache_write, irq_write, vga_write, kbd_read}))
        else $error("bus_decoder: more than one slave strobe active");
    end
  end

endmodule

`default_nettype wire

//--- rtl/main_sram.sv
`timescale 1ns/1ps
`default_nettype none
`include "periph_cfg.svh"

module main_sram (
  input  wire logic                  clk,
  input  wire logic                  reset_n,
  input  wire logic                  read,
  input  wire logic                  write,
  input  wire periph_pkg::sram_addr_t addr,
  input  wire periph_pkg::bus_data_t  writedata,
  input  wire periph_pkg::byte_en_t   byteenable,
  output periph_pkg::bus_data_t       readdata,
  output logic                        waitrequest
);
  import periph_pkg::*;

  bus_data_t mem [0:`PERIPH_SRAM_WORDS-1];
  logic      read_ack;

  always_ff @(posedge clk) begin
    if (write) begin
      for (int i = 0; i < $bits(byte_en_t); i++) begin
        if (byteenable[i]) begin
          mem[addr][8*i +: 8] <= writedata[8*i +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    readdata <= mem[addr]; // valid one cycle after the address
  end

  // first read cycle waits and the ack drops once the strobe goes away
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      read_ack <= 1'b0;
    end else if (read && !read_ack) begin
      read_ack <= 1'b1;
    end else if (!read && read_ack) begin
      read_ack <= 1'b0;
    end
  end

  assign waitrequest = read && !read_ack;

  // a read in wait completes in the next cycle at the same address
  assert property (@(posedge clk) disable iff (!reset_n)
    waitrequest |=> read && $stable(addr) && !waitrequest)
    else $error("main_sram: read dropped, moved or held in wait past one cycle");

endmodule

`default_nettype wire

//--- rtl/ctrl_regs.sv
`timescale 1ns/1ps
`default_nettype none
`include "periph_cfg.svh"

module ctrl_regs (
  input  wire logic                   clk,
  input  wire logic                   reset_n,
  input  wire logic                   cache_write,
  input  wire logic                   vga_write,
  input  wire periph_pkg::reg_offset_t offset,
  input  wire periph_pkg::bus_data_t   writedata,
  output logic                         flush_cache,
  output periph_pkg::flush_page_t      flush_page,
  output periph_pkg::vga_mode_t        vga_mode,
  output periph_pkg::line_addr_t       vga_line_base,
  output logic                         vga_block
);
  import periph_pkg::*;

  // cache control, single register at offset 0
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      flush_cache <= 1'b0;
      flush_page  <= '0;
    end else if (cache_write && offset == 14'd0) begin
      flush_cache <= writedata[31];   // request flag
      flush_page  <= writedata[14:0];
    end
  end

  // vga control
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      vga_mode      <= vga_mode_t'(`PERIPH_VGA_MODE_RESET);
      vga_line_base <= '0;
      vga_block     <= 1'b0;
    end else if (vga_write) begin
      case (offset)
        14'd0: begin
          vga_mode <= writedata[1:0];
        end
        14'd1: begin
          vga_line_base <= writedata[15:0]; // first line fetched by scan-out
        end
        14'd2: begin
          vga_block <= writedata[0];        // blanks the display
        end
        default: begin
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- rtl/irq_ctrl.sv
`timescale 1ns/1ps
`default_nettype none
`include "periph_cfg.svh"

module irq_ctrl (
  input  wire logic                   clk,
  input  wire logic                   reset_n,
  input  wire logic                   write,
  input  wire periph_pkg::reg_offset_t offset,
  input  wire periph_pkg::bus_data_t   writedata,
  input  wire logic                   kbd_valid,
  output periph_pkg::bus_data_t        readdata,
  output logic                         irq_req
);
  import periph_pkg::*;

  irq_vec_t pending;
  logic     kbd_ack;  // source level already taken

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      pending <= '0;
      kbd_ack <= 1'b0;
    end else begin
      if (write && offset == 14'd0) begin
        pending <= pending & ~writedata; // write one to clear
      end

      // later assignment, so a new event beats a clear in the same cycle
      if (kbd_valid && !kbd_ack) begin
        pending[`PERIPH_IRQ_KBD_BIT] <= 1'b1;
        kbd_ack <= 1'b1;
      end else if (!kbd_valid && kbd_ack) begin
        kbd_ack <= 1'b0;   // rearm for the next rising edge
      end
    end
  end

  assign readdata = pending;
  assign irq_req  = |pending;

endmodule

`default_nettype wire

//--- rtl/ps2_keyboard_rx.sv
`timescale 1ns/1ps
`default_nettype none
`include "periph_cfg.svh"

module ps2_keyboard_rx (
  input  wire logic              clk,
  input  wire logic              reset_n,
  input  wire logic              ps2_clk,
  input  wire logic              ps2_data,
  input  wire logic              read,
  output periph_pkg::ps2_frame_t frame,
  output logic                   valid
);
  import periph_pkg::*;

  logic        clk_sync0;
  logic        clk_sync1;
  logic        clk_prev;
  logic        data_sync0;
  logic        data_sync1;
  logic        clk_rise;
  logic        restart;
  logic        last_bit;
  logic [15:0] idle_cnt;
  logic [3:0]  bit_pos;
  ps2_frame_t  rx_bits;

  // ps2 lines idle high, so reset to 1 avoids a false edge
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      clk_sync0  <= 1'b1;
      clk_sync1  <= 1'b1;
      clk_prev   <= 1'b1;
      data_sync0 <= 1'b1;
      data_sync1 <= 1'b1;
    end else begin
      clk_sync0  <= ps2_clk;
      clk_sync1  <= clk_sync0;
      clk_prev   <= clk_sync1;
      data_sync0 <= ps2_data; // same depth as the clock path
      data_sync1 <= data_sync0;
    end
  end

  assign clk_rise = clk_sync1 && !clk_prev;
  assign restart  = clk_rise && idle_cnt == `PERIPH_KBD_IDLE_LIMIT; // stale partial frame
  assign last_bit = clk_rise && !restart && bit_pos == 4'd10;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      idle_cnt <= '0;
      bit_pos  <= '0;
      valid    <= 1'b0;
    end else begin
      if (idle_cnt != `PERIPH_KBD_IDLE_LIMIT) begin
        idle_cnt <= idle_cnt + 16'd1;
      end

      if (clk_rise) begin
        idle_cnt <= '0;
        if (restart) begin
          bit_pos <= 4'd1;   // this edge was bit 0
        end else if (last_bit) begin
          bit_pos <= '0;
          valid   <= 1'b1;
        end else begin
          bit_pos <= bit_pos + 4'd1;
        end
      end

      if (read) begin
        valid <= 1'b0;
      end
    end
  end

  // frame only changes on completion
  always_ff @(posedge clk) begin
    if (restart) begin
      rx_bits[0] <= data_sync1;
    end else if (clk_rise) begin
      rx_bits[bit_pos] <= data_sync1;
    end
    if (last_bit) begin
      frame <= {data_sync1, rx_bits[9:0]};
    end
  end

  assert property (@(posedge clk) disable iff (!reset_n) bit_pos <= 4'd10)
    else $error("ps2_keyboard_rx: bit position past stop bit");

endmodule

`default_nettype wire

//--- rtl/periph_system.sv
`timescale 1ns/1ps
`default_nettype none

module periph_system (
  input  wire logic                  clk,
  input  wire logic                  reset_n,
  input  wire periph_pkg::bus_addr_t bus_address,
  input  wire logic                  bus_read,
  input  wire logic                  bus_write,
  input  wire periph_pkg::bus_data_t bus_writedata,
  input  wire periph_pkg::byte_en_t  bus_byteenable,
  output periph_pkg::bus_data_t      bus_readdata,
  output logic                       bus_waitrequest,
  input  wire logic                  ps2_clk,
  input  wire logic                  ps2_data,
  output logic                       irq_req,
  output logic                       flush_cache,
  output periph_pkg::flush_page_t    flush_page,
  output periph_pkg::vga_mode_t      vga_mode,
  output periph_pkg::line_addr_t     vga_line_base,
  output logic                       vga_block
);
  import periph_pkg::*;

  reg_offset_t offset;
  sram_addr_t  sram_addr;
  logic        sram_read;
  logic        sram_write;
  logic        cache_write;
  logic        irq_write;
  logic        vga_write;
  logic        kbd_read;
  bus_data_t   sram_readdata;
  logic        sram_waitrequest;
  bus_data_t   irq_readdata;
  ps2_frame_t  kbd_frame;
  logic        kbd_valid;

  bus_decoder bus_decoder_i (
    .bus_address      (bus_address),
    .bus_read         (bus_read),
    .bus_write        (bus_write),
    .sram_readdata    (sram_readdata),
    .irq_readdata     (irq_readdata),
    .sram_waitrequest (sram_waitrequest),
    .kbd_frame        (kbd_frame),
    .kbd_valid        (kbd_valid),
    .offset           (offset),
    .sram_addr        (sram_addr),
    .sram_read        (sram_read),
    .sram_write       (sram_write),
    .cache_write      (cache_write),
    .irq_write        (irq_write),
    .vga_write        (vga_write),
    .kbd_read         (kbd_read),
    .bus_readdata     (bus_readdata),
    .bus_waitrequest  (bus_waitrequest)
  );

  main_sram main_sram_i (
    .clk         (clk),
    .reset_n     (reset_n),
    .read        (sram_read),
    .write       (sram_write),
    .addr        (sram_addr),
    .writedata   (bus_writedata),
    .byteenable  (bus_byteenable),
    .readdata    (sram_readdata),
    .waitrequest (sram_waitrequest)
  );

  ctrl_regs ctrl_regs_i (
    .clk           (clk),
    .reset_n       (reset_n),
    .cache_write   (cache_write),
    .vga_write     (vga_write),
    .offset        (offset),
    .writedata     (bus_writedata),
    .flush_cache   (flush_cache),
    .flush_page    (flush_page),
    .vga_mode      (vga_mode),
    .vga_line_base (vga_line_base),
    .vga_block     (vga_block)
  );

  irq_ctrl irq_ctrl_i (
    .clk       (clk),
    .reset_n   (reset_n),
    .write     (irq_write),
    .offset    (offset),
    .writedata (bus_writedata),
    .kbd_valid (kbd_valid),
    .readdata  (irq_readdata),
    .irq_req   (irq_req)
  );

  ps2_keyboard_rx ps2_keyboard_rx_i (
    .clk      (clk),
    .reset_n  (reset_n),
    .ps2_clk  (ps2_clk),
    .ps2_data (ps2_data),
    .read     (kbd_read),
    .frame    (kbd_frame),
    .valid    (kbd_valid)
  );

endmodule

`default_nettype wire

//--- dv/tb_periph_system.sv
`timescale 1ns/1ps
`default_nettype none
`include "periph_cfg.svh"

module tb_periph_system;
  import periph_pkg::*;

  localparam int clk_period      = 40;
  localparam int sram_tests      = 24;
  localparam int num_ops         = 3 * sram_tests + 24;
  localparam int frame_cycles    = 11 * 16 + 16;  // 11 ps2 bits plus settle
  localparam int idle_gap        = `PERIPH_KBD_IDLE_LIMIT + 100;
  localparam int watchdog_cycles = num_ops * 40 + 3 * frame_cycles + idle_gap + 10;

  logic        clk = 1'b0;
  logic        reset_n;
  bus_addr_t   bus_address;
  logic        bus_read;
  logic        bus_write;
  bus_data_t   bus_writedata;
  byte_en_t    bus_byteenable;
  bus_data_t   bus_readdata;
  logic        bus_waitrequest;
  logic        ps2_clk;
  logic        ps2_data;
  logic        irq_req;
  logic        flush_cache;
  flush_page_t flush_page;
  vga_mode_t   vga_mode;
  line_addr_t  vga_line_base;
  logic        vga_block;

  // reference model state
  bus_data_t   shadow_mem [0:`PERIPH_SRAM_WORDS-1];
  irq_vec_t    model_irq = '0;
  logic        model_kbd_valid = 1'b0;
  ps2_frame_t  model_kbd_frame = '0;
  logic        model_flush_cache = 1'b0;
  flush_page_t model_flush_page = '0;
  vga_mode_t   model_vga_mode = vga_mode_t'(`PERIPH_VGA_MODE_RESET);
  line_addr_t  model_vga_line_base = '0;
  logic        model_vga_block = 1'b0;

  bus_data_t   rng_state = 32'd34928;
  int          checks = 0;
  int          errors = 0;
  sram_addr_t  test_idx [sram_tests];

  periph_system periph_system_i (
    .clk             (clk),
    .reset_n         (reset_n),
    .bus_address     (bus_address),
    .bus_read        (bus_read),
    .bus_write       (bus_write),
    .bus_writedata   (bus_writedata),
    .bus_byteenable  (bus_byteenable),
    .bus_readdata    (bus_readdata),
    .bus_waitrequest (bus_waitrequest),
    .ps2_clk         (ps2_clk),
    .ps2_data        (ps2_data),
    .irq_req         (irq_req),
    .flush_cache     (flush_cache),
    .flush_page      (flush_page),
    .vga_mode        (vga_mode),
    .vga_line_base   (vga_line_base),
    .vga_block       (vga_block)
  );

  always #(clk_period / 2) clk = ~clk;

  function automatic bus_data_t next_random();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic bus_addr_t sram_address(sram_addr_t idx);
    return {`PERIPH_REGION_SRAM, 5'd0, idx, 2'b00};
  endfunction

  // start 0, data lsb first, odd parity, stop 1
  function automatic ps2_frame_t make_frame(logic [7:0] data);
    return {1'b1, ~^data, data, 1'b0};
  endfunction

  function automatic bus_data_t expected_read(bus_addr_t addr);
    case (addr[31:16])
      `PERIPH_REGION_SRAM: return shadow_mem[addr[10:2]];
      `PERIPH_REGION_IRQ:  return model_irq;
      `PERIPH_REGION_KBD:  return {20'd0, model_kbd_valid, model_kbd_frame};
      default:             return '0;  // cache, vga and unmapped space
    endcase
  endfunction

  function automatic void model_write(bus_addr_t addr, bus_data_t data, byte_en_t be);
    reg_offset_t off;
    off = addr[15:2];
    if (addr[31:16] == `PERIPH_REGION_SRAM) begin
      for (int i = 0; i < 4; i++) begin
        if (be[i]) begin
          shadow_mem[addr[10:2]][8*i +: 8] = data[8*i +: 8];
        end
      end
    end else if (addr[31:16] == `PERIPH_REGION_CACHE && off == 14'd0) begin
      model_flush_cache = data[31];
      model_flush_page  = data[14:0];
    end else if (addr[31:16] == `PERIPH_REGION_IRQ && off == 14'd0) begin
      model_irq = model_irq & ~data;  // write one to clear
    end else if (addr[31:16] == `PERIPH_REGION_VGA) begin
      if (off == 14'd0) begin
        model_vga_mode = data[1:0];
      end else if (off == 14'd1) begin
        model_vga_line_base = data[15:0];
      end else if (off == 14'd2) begin
        model_vga_block = data[0];
      end
    end
  endfunction

  task automatic check_data(string what, bus_data_t got, bus_data_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t ns: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_frame(string what, ps2_frame_t got, ps2_frame_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t ns: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_bit(string what, logic got, logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t ns: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  // one access held until waitrequest is low
  task automatic bus_access(bus_addr_t addr, logic is_write, bus_data_t wdata, byte_en_t be,
                            output bus_data_t rdata);
    int waits;
    int exp_waits;
    waits = 0;
    exp_waits = (!is_write && addr[31:16] == `PERIPH_REGION_SRAM) ? 1 : 0;
    @(posedge clk);
    bus_address    <= addr;
    bus_read       <= !is_write;
    bus_write      <= is_write;
    bus_writedata  <= wdata;
    bus_byteenable <= be;
    @(negedge clk);
    while (bus_waitrequest) begin
      waits++;
      @(negedge clk);
    end
    rdata = bus_readdata;
    @(posedge clk);  // access completes here
    bus_read  <= 1'b0;
    bus_write <= 1'b0;
    if (is_write) begin
      model_write(addr, wdata, be);
    end else if (addr[31:16] == `PERIPH_REGION_KBD) begin
      model_kbd_valid = 1'b0;
    end
    check_bit($sformatf("wait count %0d at %h", waits, addr), waits == exp_waits, 1'b1);
  endtask

  task automatic write_word(bus_addr_t addr, bus_data_t data, byte_en_t be);
    bus_data_t unused;
    bus_access(addr, 1'b1, data, be, unused);
  endtask

  task automatic read_word(bus_addr_t addr, output bus_data_t data);
    bus_access(addr, 1'b0, '0, 4'hf, data);
  endtask

  // data changes while ps2_clk is low and the receiver samples on the rise
  task automatic send_ps2_bits(ps2_frame_t frame, int nbits);
    for (int i = 0; i < nbits; i++) begin
      @(posedge clk);
      ps2_data <= frame[i];
      ps2_clk  <= 1'b0;
      repeat (8) @(posedge clk);
      ps2_clk  <= 1'b1;
      repeat (7) @(posedge clk);
    end
    repeat (8) @(posedge clk);  // valid within 3 cycles and irq one later
  endtask

  task automatic check_ctrl_outputs();
    @(negedge clk);
    check_bit("flush_cache", flush_cache, model_flush_cache);
    check_data("flush_page", bus_data_t'(flush_page), bus_data_t'(model_flush_page));
    check_data("vga_mode", bus_data_t'(vga_mode), bus_data_t'(model_vga_mode));
    check_data("vga_line_base", bus_data_t'(vga_line_base), bus_data_t'(model_vga_line_base));
    check_bit("vga_block", vga_block, model_vga_block);
  endtask

  // every completed read against the reference model
  always @(negedge clk) begin
    if (reset_n && bus_read && !bus_waitrequest) begin
      check_data($sformatf("read at %h", bus_address), bus_readdata,
                 expected_read(bus_address));
    end
  end

  initial begin
    #(watchdog_cycles * clk_period);
    $display("watchdog expired after %0d cycles, tests did not finish", watchdog_cycles);
    $display("STATUS: FAIL");
    $finish;
  end

  initial begin
    bus_data_t  rd;
    bus_data_t  rnd;
    ps2_frame_t frame;
    reset_n        <= 1'b0;
    bus_address    <= '0;
    bus_read       <= 1'b0;
    bus_write      <= 1'b0;
    bus_writedata  <= '0;
    bus_byteenable <= '0;
    ps2_clk        <= 1'b1;  // ps2 lines idle high
    ps2_data       <= 1'b1;
    repeat (3) @(posedge clk);
    reset_n <= 1'b1;
    @(negedge clk);
    check_bit("waitrequest idle", bus_waitrequest, 1'b0);
    check_bit("irq_req after reset", irq_req, 1'b0);
    check_ctrl_outputs();

    // sram gets full words first so no byte stays undefined
    for (int i = 0; i < sram_tests; i++) begin
      rnd = next_random();
      test_idx[i] = rnd[8:0];
      write_word(sram_address(test_idx[i]), next_random(), 4'hf);
    end
    for (int i = 0; i < sram_tests; i++) begin
      rnd = next_random();
      write_word(sram_address(test_idx[i]), next_random(), rnd[3:0]);
    end
    for (int i = 0; i < sram_tests; i++) begin
      read_word(sram_address(test_idx[i]), rd);
    end

    // cache and vga control
    write_word({`PERIPH_REGION_CACHE, 16'h0000}, 32'h8000_1234, 4'hf);
    check_ctrl_outputs();
    write_word({`PERIPH_REGION_CACHE, 16'h0004}, 32'h0000_7fff, 4'hf);  // ignored offset
    write_word({`PERIPH_REGION_VGA, 16'h0000}, 32'h0000_0001, 4'hf);
    write_word({`PERIPH_REGION_VGA, 16'h0004}, 32'h0000_beef, 4'hf);
    write_word({`PERIPH_REGION_VGA, 16'h0008}, 32'h0000_0001, 4'hf);
    check_ctrl_outputs();
    read_word({`PERIPH_REGION_CACHE, 16'h0000}, rd);
    read_word({`PERIPH_REGION_VGA, 16'h0004}, rd);
    read_word(32'h0300_0000, rd);
    read_word(32'h0203_0010, rd);

    // keyboard frame and its interrupt
    rnd = next_random();
    frame = make_frame(rnd[7:0]);
    send_ps2_bits(frame, 11);
    model_kbd_valid = 1'b1;
    model_kbd_frame = frame;
    model_irq[`PERIPH_IRQ_KBD_BIT] = 1'b1;
    @(negedge clk);
    check_bit("irq_req after frame", irq_req, 1'b1);
    read_word({`PERIPH_REGION_KBD, 16'h0000}, rd);
    check_frame("kbd frame", rd[10:0], frame);
    check_bit("kbd valid", rd[11], 1'b1);
    read_word({`PERIPH_REGION_KBD, 16'h0000}, rd);
    check_bit("kbd valid after read", rd[11], 1'b0);
    read_word({`PERIPH_REGION_IRQ, 16'h0000}, rd);
    check_data("irq pending", rd, 32'h0000_0001);
    write_word({`PERIPH_REGION_IRQ, 16'h0000}, 32'h0000_0001, 4'hf);
    @(negedge clk);
    check_bit("irq_req after clear", irq_req, 1'b0);

    // abandoned partial frame then silence past the idle limit
    rnd = next_random();
    send_ps2_bits(make_frame(rnd[7:0]), 4);
    repeat (idle_gap) @(posedge clk);
    rnd = next_random();
    frame = make_frame(rnd[7:0]);
    send_ps2_bits(frame, 11);
    model_kbd_valid = 1'b1;
    model_kbd_frame = frame;
    model_irq[`PERIPH_IRQ_KBD_BIT] = 1'b1;
    @(negedge clk);
    check_bit("irq_req after second frame", irq_req, 1'b1);
    read_word({`PERIPH_REGION_KBD, 16'h0000}, rd);
    check_frame("kbd frame after idle restart", rd[10:0], frame);
    write_word({`PERIPH_REGION_IRQ, 16'h0000}, 32'h0000_0001, 4'hf);
    @(negedge clk);
    check_bit("irq_req after second clear", irq_req, 1'b0);

    repeat (2) @(posedge clk);
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- periph_system.f
+incdir+rtl
rtl/periph_pkg.sv
rtl/bus_decoder.sv
rtl/main_sram.sv
rtl/ctrl_regs.sv
rtl/irq_ctrl.sv
rtl/ps2_keyboard_rx.sv
rtl/periph_system.sv
dv/tb_periph_system.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the periph_system testbench with Verilator

cd "$(dirname "$0")" || exit 1

top=tb_periph_system

if ! verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module "$top" -f periph_system.f; then
  echo "verilator compile failed"
  exit 1
fi

output=$(./obj_dir/V"$top")
status=$?
printf '%s\n' "$output"

if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "STATUS: PASS"; then
  exit 0
fi

echo "pass message not found in simulation output"
exit 1
